//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/rv_core_fetch.sv
      - src/rv_core_decoder.sv
      - src/rv_core_regfile.sv
      - src/rv_core_alu.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/rv_core_sva.sv
      - dv/rv_core_tb.sv

//--- dv/rv_core_sva.sv
// Bound concurrent assertions on the fetch handshake and the store strobe

`include "rv_core_macros.svh"

module rv_core_sva (
  input logic                clk,
  input logic                rst_ni,
  input logic                instr_req_i,
  input logic [`RV_XLEN-1:0] instr_addr_i,
  input logic                core_busy_i,
  input logic                data_req_i
);

  timeunit 1ns;
  timeprecision 1ns;

  // Count of failed assertions
  int fail_cnt = 0;

  // Only one fetch in flight
  req_while_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i |-> !core_busy_i)
    else begin
      fail_cnt++;
      $error("instruction request issued while a fetch is outstanding");
    end

  // Store strobe lasts exactly one cycle
  store_one_cycle: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_i |=> !data_req_i)
    else begin
      fail_cnt++;
      $error("data request held for more than one cycle");
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i |-> (instr_addr_i[1:0] == 2'b00))
    else begin
      fail_cnt++;
      $error("instruction address not word aligned");
    end

  // Both strobes quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk)
    !rst_ni |-> (!instr_req_i && !data_req_i))
    else begin
      fail_cnt++;
      $error("request strobe high during reset");
    end

endmodule

bind rv_core rv_core_sva sva_i (
  .clk          ( clk          ),
  .rst_ni       ( rst_ni       ),
  .instr_req_i  ( instr_req_o  ),
  .instr_addr_i ( instr_addr_o ),
  .core_busy_i  ( core_busy_o  ),
  .data_req_i   ( data_req_o   )
);

//--- dv/rv_core_tb.sv
// Core testbench with clock, reset, instruction memory model, program table and watchdog

`include "rv_core_macros.svh"

module rv_core_tb import rv_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int NTESTS = 4;
  localparam int MAXP = 16;
  localparam int MAXS = 7;
  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic                clk, rst_ni, fetch_enable_i, instr_rvalid_i;
  logic                instr_req_o, data_req_o, core_busy_o;
  logic [`RV_XLEN-1:0] boot_addr_i, instr_rdata_i, instr_addr_o, data_addr_o, data_wdata_o;

  ////////////////////
  // Program table
  ////////////////////

  string               test_name [NTESTS];
  logic [`RV_XLEN-1:0] boot_tab  [NTESTS];
  instr_u              prog      [NTESTS][MAXP];
  int                  prog_len  [NTESTS];
  logic [`RV_XLEN-1:0] exp_addr  [NTESTS][MAXS];
  logic [`RV_XLEN-1:0] exp_data  [NTESTS][MAXS];
  int                  exp_cnt   [NTESTS];
  logic                table_ready = 1'b0;

  int          cur_row, store_idx, errors, checks, failed_tests;
  int          wait_cnt;
  logic [31:0] pend_addr;
  logic [15:0] lfsr_q = 16'd69;

  rv_core uut (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .core_busy_o    ( core_busy_o    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Instruction encoders, one per format
  function automatic instr_u op_rr(logic [2:0] f3, logic [6:0] f7, logic [4:0] rd,
                                   logic [4:0] rs1, logic [4:0] rs2);
    instr_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
    return w;
  endfunction

  function automatic instr_u op_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                    logic [11:0] imm);
    instr_u w;
    w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
    return w;
  endfunction

  function automatic instr_u store_word(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    instr_u w;
    w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010, imm_lo: imm[4:0],
            opcode: OPC_STORE};
    return w;
  endfunction

  // f3 000 is BEQ, 001 is BNE
  function automatic instr_u branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    instr_u w;
    w.b = '{imm12: off[12], imm10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
            imm4_1: off[4:1], imm11: off[11], opcode: OPC_BRANCH};
    return w;
  endfunction

  function automatic instr_u lui_word(logic [4:0] rd, logic [19:0] imm);
    instr_u w;
    w.u = '{imm: imm, rd: rd, opcode: OPC_LUI};
    return w;
  endfunction

  function automatic instr_u jal_word(logic [4:0] rd, logic [20:0] off);
    instr_u w;
    w.j = '{imm20: off[20], imm10_1: off[10:1], imm11: off[11], imm19_12: off[19:12],
            rd: rd, opcode: OPC_JAL};
    return w;
  endfunction

  task automatic add_instr(int row, instr_u w);
    prog[row][prog_len[row]] = w;
    prog_len[row]++;
  endtask

  task automatic add_store(int row, logic [31:0] addr, logic [31:0] data);
    exp_addr[row][exp_cnt[row]] = addr;
    exp_data[row][exp_cnt[row]] = data;
    exp_cnt[row]++;
  endtask

  task automatic build_table();
    // Row 0, add/sub/compare and shifts
    test_name[0] = "alu_ops";
    boot_tab[0]  = 32'h0000_1000;
    add_instr(0, op_imm(3'b000, 5'd1, 5'd0, 12'd100));
    add_instr(0, op_imm(3'b000, 5'd2, 5'd0, -12'd7));
    add_instr(0, op_rr(3'b000, 7'h20, 5'd3, 5'd1, 5'd2));  // SUB
    add_instr(0, op_rr(3'b010, 7'h00, 5'd4, 5'd2, 5'd1));
    add_instr(0, op_rr(3'b010, 7'h00, 5'd5, 5'd1, 5'd2));
    add_instr(0, op_imm(3'b001, 5'd6, 5'd1, 12'd4));
    add_instr(0, op_imm(3'b101, 5'd7, 5'd2, 12'd28));
    add_instr(0, op_rr(3'b100, 7'h00, 5'd8, 5'd1, 5'd2));
    add_instr(0, op_rr(3'b000, 7'h00, 5'd9, 5'd1, 5'd2));
    add_instr(0, store_word(5'd0, 5'd3, 12'h100));
    add_instr(0, store_word(5'd0, 5'd4, 12'h104));
    add_instr(0, store_word(5'd0, 5'd5, 12'h108));
    add_instr(0, store_word(5'd0, 5'd6, 12'h10C));
    add_instr(0, store_word(5'd0, 5'd7, 12'h110));
    add_instr(0, store_word(5'd1, 5'd8, -12'd4));
    add_instr(0, store_word(5'd0, 5'd9, 12'h114));
    add_store(0, 32'h100, 32'd107);
    add_store(0, 32'h104, 32'd1);
    add_store(0, 32'h108, 32'd0);
    add_store(0, 32'h10C, 32'h640);
    add_store(0, 32'h110, 32'hF);
    add_store(0, 32'h060, 32'hFFFF_FF9D);
    add_store(0, 32'h114, 32'd93);
    // Row 1, logic ops and register shifts
    test_name[1] = "logic_shift";
    boot_tab[1]  = 32'h0000_1100;
    add_instr(1, op_imm(3'b000, 5'd1, 5'd0, 12'h5A3));
    add_instr(1, op_imm(3'b110, 5'd2, 5'd1, 12'h00C));
    add_instr(1, op_imm(3'b111, 5'd3, 5'd1, 12'h0F0));
    add_instr(1, op_imm(3'b100, 5'd4, 5'd1, -12'd1));
    add_instr(1, op_imm(3'b000, 5'd5, 5'd0, 12'd3));
    add_instr(1, op_rr(3'b001, 7'h00, 5'd6, 5'd1, 5'd5));
    add_instr(1, op_rr(3'b101, 7'h00, 5'd7, 5'd4, 5'd5));
    add_instr(1, op_rr(3'b111, 7'h00, 5'd8, 5'd2, 5'd4));
    add_instr(1, op_rr(3'b110, 7'h00, 5'd9, 5'd3, 5'd5));
    add_instr(1, op_imm(3'b010, 5'd10, 5'd4, -12'd1000));
    add_instr(1, store_word(5'd0, 5'd6, 12'h200));
    add_instr(1, store_word(5'd0, 5'd7, 12'h204));
    add_instr(1, store_word(5'd0, 5'd8, 12'h208));
    add_instr(1, store_word(5'd0, 5'd9, 12'h20C));
    add_instr(1, store_word(5'd0, 5'd10, 12'h210));
    add_store(1, 32'h200, 32'h2D18);
    add_store(1, 32'h204, 32'h1FFF_FF4B);
    add_store(1, 32'h208, 32'h0000_000C);
    add_store(1, 32'h20C, 32'h0000_00A3);
    add_store(1, 32'h210, 32'd1);
    // Row 2, JAL hops over one store, x0 stays zero
    test_name[2] = "lui_jal_x0";
    boot_tab[2]  = 32'h0000_1200;
    add_instr(2, lui_word(5'd1, 20'h12345));
    add_instr(2, op_imm(3'b000, 5'd1, 5'd1, 12'h678));
    add_instr(2, jal_word(5'd2, 21'd8));
    add_instr(2, store_word(5'd0, 5'd1, 12'h300));
    add_instr(2, op_imm(3'b000, 5'd0, 5'd1, 12'd5));
    add_instr(2, store_word(5'd0, 5'd0, 12'h304));
    add_instr(2, store_word(5'd0, 5'd1, 12'h308));
    add_instr(2, store_word(5'd0, 5'd2, 12'h30C));
    add_store(2, 32'h304, 32'd0);
    add_store(2, 32'h308, 32'h1234_5678);
    add_store(2, 32'h30C, 32'h0000_120C);
    // Row 3, two taken and two not-taken branches
    test_name[3] = "branches";
    boot_tab[3]  = 32'h0000_1300;
    add_instr(3, op_imm(3'b000, 5'd1, 5'd0, 12'd5));
    add_instr(3, op_imm(3'b000, 5'd2, 5'd0, 12'd5));
    add_instr(3, op_imm(3'b000, 5'd3, 5'd0, 12'd9));
    add_instr(3, branch_word(3'b000, 5'd1, 5'd2, 13'd8));
    add_instr(3, store_word(5'd0, 5'd3, 12'h400));
    add_instr(3, branch_word(3'b001, 5'd1, 5'd3, 13'd8));
    add_instr(3, store_word(5'd0, 5'd1, 12'h404));
    add_instr(3, branch_word(3'b000, 5'd1, 5'd3, 13'd8));
    add_instr(3, store_word(5'd0, 5'd2, 12'h408));
    add_instr(3, branch_word(3'b001, 5'd1, 5'd2, 13'd8));
    add_instr(3, store_word(5'd0, 5'd3, 12'h40C));
    add_store(3, 32'h408, 32'd5);
    add_store(3, 32'h40C, 32'd9);
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Words outside the loaded program read as a no-op
  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    int idx;
    idx = (addr - boot_tab[cur_row]) >> 2;
    if (addr >= boot_tab[cur_row] && idx < prog_len[cur_row]) begin
      return prog[cur_row][idx];
    end
    return NOP_WORD;
  endfunction

  always @(negedge clk) begin : imem_model
    logic [1:0] delay_bits;
    if (!rst_ni) begin
      wait_cnt = 0;
      instr_rvalid_i <= 1'b0;
    end else begin
      instr_rvalid_i <= 1'b0;
      if (wait_cnt > 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= fetch_word(pend_addr);
        end
      end
      if (instr_req_o) begin
        // 1 to 4 cycles, one LFSR step per bit
        delay_bits[0] = lfsr_q[0];
        lfsr_q        = lfsr_next(lfsr_q);
        delay_bits[1] = lfsr_q[0];
        lfsr_q        = lfsr_next(lfsr_q);
        wait_cnt      = 1 + delay_bits;
        pend_addr     = instr_addr_o;
      end
    end
  end

  // Store monitor against the expected sequence of the current row
  always @(negedge clk) begin
    if (rst_ni && data_req_o) begin
      if (store_idx < exp_cnt[cur_row]) begin
        check_value($sformatf("%s store %0d address", test_name[cur_row], store_idx),
                    data_addr_o, exp_addr[cur_row][store_idx]);
        check_value($sformatf("%s store %0d data", test_name[cur_row], store_idx),
                    data_wdata_o, exp_data[cur_row][store_idx]);
      end else begin
        errors++;
        $display("Unexpected extra store to 0x%08h in test %s", data_addr_o,
                 test_name[cur_row]);
      end
      store_idx++;
    end
  end

  task automatic run_test(int t);
    int errs_before;
    errs_before = errors;
    @(negedge clk);
    rst_ni         <= 1'b0;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= boot_tab[t];
    cur_row   = t;
    store_idx = 0;
    repeat (10) @(negedge clk);
    rst_ni         <= 1'b1;
    fetch_enable_i <= 1'b1;
    // First fetch one cycle after reset release, from the boot address
    @(negedge clk);
    check_value("request after reset", instr_req_o, 1'b1);
    check_value("first fetch address", instr_addr_o, boot_tab[t]);
    // Waiting on the first word
    @(negedge clk);
    check_value("busy after request", core_busy_o, 1'b1);
    while (store_idx < exp_cnt[t]) @(negedge clk);
    fetch_enable_i <= 1'b0;
    @(negedge clk);
    while (core_busy_o || instr_req_o) @(negedge clk);
    // Core must stay idle with fetch disabled
    repeat (6) begin
      check_value("request while disabled", instr_req_o, 1'b0);
      check_value("busy while disabled", core_busy_o, 1'b0);
      @(negedge clk);
    end
    check_value("store count", store_idx, exp_cnt[t]);
    if (errors == errs_before) begin
      $display("Test %-12s ok, %0d stores", test_name[t], exp_cnt[t]);
    end else begin
      failed_tests++;
      $display("Test %-12s FAILED with %0d errors", test_name[t], errors - errs_before);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    build_table();
    table_ready = 1'b1;
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    errors += uut.sva_i.fail_cnt;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             NTESTS, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog, worst-case latency per instruction with margin plus reset per row
  initial begin
    int limit;
    wait (table_ready);
    limit = 0;
    for (int t = 0; t < NTESTS; t++) begin
      limit += prog_len[t];
    end
    limit = limit * 4 * 2 + NTESTS * (10 + 30);
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+src
src/rv_core_pkg.sv
src/rv_core_fetch.sv
src/rv_core_decoder.sv
src/rv_core_regfile.sv
src/rv_core_alu.sv
src/rv_core.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

//--- src/rv_core.sv
// Core top level with stage wiring, write-back select and store port

`include "rv_core_macros.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                clk,
  input  logic                rst_ni,
  input  logic [`RV_XLEN-1:0] boot_addr_i,
  input  logic                fetch_enable_i,
  output logic                instr_req_o,
  output logic [`RV_XLEN-1:0] instr_addr_o,
  input  logic                instr_rvalid_i,
  input  logic [`RV_XLEN-1:0] instr_rdata_i,
  output logic                data_req_o,
  output logic [`RV_XLEN-1:0] data_addr_o,
  output logic [`RV_XLEN-1:0] data_wdata_o,
  output logic                core_busy_o
);

  instr_u                instr;
  logic [`RV_REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [`RV_XLEN-1:0]   imm, rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]   alu_b, alu_result, wb_data, pc, pc_target;
  alu_op_e               alu_op;
  logic                  use_imm, reg_we, is_branch, branch_ne, is_jal, is_store;
  logic                  alu_equal, pc_jump, store_fire, data_req_q;
  logic [`RV_XLEN-1:0]   data_addr_q, data_wdata_q;

  assign instr = instr_rdata_i;

  ////////////////////
  // Fetch
  ////////////////////

  rv_core_fetch fetch_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .pc_jump_i      ( pc_jump        ),
    .pc_target_i    ( pc_target      ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .pc_o           ( pc             ),
    .busy_o         ( core_busy_o    )
  );

  ////////////////////
  // Decode / execute
  ////////////////////

  rv_core_decoder decoder_i (
    .instr_i     ( instr     ),
    .rs1_addr_o  ( rs1_addr  ),
    .rs2_addr_o  ( rs2_addr  ),
    .rd_addr_o   ( rd_addr   ),
    .imm_o       ( imm       ),
    .alu_op_o    ( alu_op    ),
    .use_imm_o   ( use_imm   ),
    .reg_we_o    ( reg_we    ),
    .is_branch_o ( is_branch ),
    .branch_ne_o ( branch_ne ),
    .is_jal_o    ( is_jal    ),
    .is_store_o  ( is_store  )
  );

  // JAL links PC plus step, all else from the ALU
  assign wb_data = is_jal ? pc + `RV_PC_STEP : alu_result;

  rv_core_regfile regfile_i (
    .clk       ( clk                     ),
    .rst_ni    ( rst_ni                  ),
    .raddr_a_i ( rs1_addr                ),
    .raddr_b_i ( rs2_addr                ),
    .waddr_i   ( rd_addr                 ),
    .we_i      ( reg_we & instr_rvalid_i ),
    .wdata_i   ( wb_data                 ),
    .rdata_a_o ( rs1_data                ),
    .rdata_b_o ( rs2_data                )
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_core_alu alu_i (
    .op_i        ( alu_op     ),
    .operand_a_i ( rs1_data   ),
    .operand_b_i ( alu_b      ),
    .result_o    ( alu_result ),
    .equal_o     ( alu_equal  )
  );

  // BNE takes on inequality, BEQ on equality
  assign pc_jump   = is_jal | (is_branch & (alu_equal ^ branch_ne));
  assign pc_target = pc + imm;

  ////////////////////
  // Store port
  ////////////////////

  assign store_fire = instr_rvalid_i & is_store;

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      data_req_q <= 1'b0;
    end else begin
      data_req_q <= store_fire;
    end
  end

  // Address is rs1 plus S-immediate out of the adder
  always_ff @(posedge clk) begin
    if (store_fire) begin
      data_addr_q  <= alu_result;
      data_wdata_q <= rs2_data;
    end
  end

  assign data_req_o   = data_req_q;
  assign data_addr_o  = data_addr_q;
  assign data_wdata_o = data_wdata_q;

endmodule

//--- src/rv_core_alu.sv
// ALU with add, logic, shift, signed compare and equality flag

`include "rv_core_macros.svh"

module rv_core_alu import rv_core_pkg::*; (
  input  alu_op_e             op_i,
  input  logic [`RV_XLEN-1:0] operand_a_i,
  input  logic [`RV_XLEN-1:0] operand_b_i,
  output logic [`RV_XLEN-1:0] result_o,
  output logic                equal_o
);

  logic [4:0] shamt;
  logic       less_than;

  // Shift amount from low bits of B
  assign shamt     = operand_b_i[4:0];
  assign less_than = $signed(operand_a_i) < $signed(operand_b_i);

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = operand_a_i + operand_b_i;
      ALU_SUB:    result_o = operand_a_i - operand_b_i;
      ALU_AND:    result_o = operand_a_i & operand_b_i;
      ALU_OR:     result_o = operand_a_i | operand_b_i;
      ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      ALU_SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, less_than};
      ALU_SLL:    result_o = operand_a_i << shamt;
      ALU_SRL:    result_o = operand_a_i >> shamt;
      ALU_PASS_B: result_o = operand_b_i;
      default:    result_o = '0;
    endcase
  end

  // Branch compare on full operands
  assign equal_o = (operand_a_i == operand_b_i);

endmodule

//--- src/rv_core_decoder.sv
// Field extraction, immediate generation and control decode

`include "rv_core_macros.svh"

module rv_core_decoder import rv_core_pkg::*; (
  input  instr_u                instr_i,
  output logic [`RV_REG_AW-1:0] rs1_addr_o,
  output logic [`RV_REG_AW-1:0] rs2_addr_o,
  output logic [`RV_REG_AW-1:0] rd_addr_o,
  output logic [`RV_XLEN-1:0]   imm_o,
  output alu_op_e               alu_op_o,
  output logic                  use_imm_o,
  output logic                  reg_we_o,
  output logic                  is_branch_o,
  output logic                  branch_ne_o,
  output logic                  is_jal_o,
  output logic                  is_store_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  // Same bit positions in every format
  assign rs1_addr_o = instr_i.r.rs1;
  assign rs2_addr_o = instr_i.r.rs2;
  assign rd_addr_o  = instr_i.r.rd;
  assign funct3     = instr_i.r.funct3;
  assign funct7     = instr_i.r.funct7;

  always_comb begin
    // Default is a no-op, also for unknown words
    imm_o       = '0;
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    reg_we_o    = 1'b0;
    is_branch_o = 1'b0;
    branch_ne_o = 1'b0;
    is_jal_o    = 1'b0;
    is_store_o  = 1'b0;

    case (instr_i.r.opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_imm_o = (instr_i.r.opcode == OPC_OP_IMM);
        imm_o     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        reg_we_o  = 1'b1;
        case (funct3)
          3'b000: alu_op_o = (!use_imm_o && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_op_o = ALU_SLL;
          3'b010: alu_op_o = ALU_SLT;
          3'b100: alu_op_o = ALU_XOR;
          3'b101: alu_op_o = ALU_SRL;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          default: reg_we_o = 1'b0;  // SLTU not supported
        endcase
        // funct7 is zero, except SUB; shift-immediates check imm[11:5]
        if (!use_imm_o && funct7 != 7'b0 &&
            !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
          reg_we_o = 1'b0;
        end
        // SRAI and bad shift encodings
        if (use_imm_o && funct3[1:0] == 2'b01 && funct7 != 7'b0) begin
          reg_we_o = 1'b0;
        end
      end
      OPC_LUI: begin
        imm_o     = {instr_i.u.imm, 12'b0};
        alu_op_o  = ALU_PASS_B;
        use_imm_o = 1'b1;
        reg_we_o  = 1'b1;
      end
      OPC_JAL: begin
        imm_o    = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
        reg_we_o = 1'b1;
        is_jal_o = 1'b1;
      end
      OPC_BRANCH: begin
        imm_o       = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                       instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
        // BEQ and BNE only
        is_branch_o = (funct3[2:1] == 2'b00);
        branch_ne_o = funct3[0];
      end
      OPC_STORE: begin
        // Address through the adder
        imm_o      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        use_imm_o  = 1'b1;
        is_store_o = (funct3 == 3'b010);
      end
      default: ;
    endcase
  end

endmodule

//--- src/rv_core_fetch.sv
// Program counter, idle/wait fetch controller and next-PC selection

`include "rv_core_macros.svh"

module rv_core_fetch (
  input  logic                clk,
  input  logic                rst_ni,
  input  logic [`RV_XLEN-1:0] boot_addr_i,
  input  logic                fetch_enable_i,
  input  logic                instr_rvalid_i,
  input  logic                pc_jump_i,
  input  logic [`RV_XLEN-1:0] pc_target_i,
  output logic                instr_req_o,
  output logic [`RV_XLEN-1:0] instr_addr_o,
  output logic [`RV_XLEN-1:0] pc_o,
  output logic                busy_o
);

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

  fetch_state_e        state_q;
  logic                req_q;
  logic                started_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;

  // Boot address until the first instruction retires
  assign pc_o = started_q ? pc_q : boot_addr_i;

  // Taken branch or JAL, else sequential
  assign pc_next = pc_jump_i ? pc_target_i : pc_o + `RV_PC_STEP;

  ////////////////////
  // Controller
  ////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= FETCH_IDLE;
      req_q     <= 1'b0;
      started_q <= 1'b0;
    end else begin
      case (state_q)
        FETCH_IDLE: begin
          if (req_q) begin
            // Request went out, wait for its data
            req_q   <= 1'b0;
            state_q <= FETCH_WAIT;
          end else begin
            req_q <= fetch_enable_i;
          end
        end
        FETCH_WAIT: begin
          if (instr_rvalid_i) begin
            state_q   <= FETCH_IDLE;
            // Back-to-back fetch while still enabled
            req_q     <= fetch_enable_i;
            started_q <= 1'b1;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  // PC moves only when an instruction executes
  always_ff @(posedge clk) begin
    if (state_q == FETCH_WAIT && instr_rvalid_i) begin
      pc_q <= pc_next;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_o;
  assign busy_o       = (state_q == FETCH_WAIT);

endmodule

//--- src/rv_core_macros.svh
// Width, register count and PC step constants for the core

`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

////////////////////
// Datapath
////////////////////

// One machine word, data and address alike
`define RV_XLEN 32

////////////////////
// Register file
////////////////////

// x0 counts as one of these
`define RV_NREGS 32
`define RV_REG_AW 5

// Sequential fetch increment in bytes
`define RV_PC_STEP 32'd4

`endif

//--- src/rv_core_pkg.sv
// Opcode enum, ALU operation enum and the instruction word views

`include "rv_core_macros.svh"

package rv_core_pkg;

  // Major opcodes, bits [6:0] of the word
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B  // Operand B straight through, for LUI
  } alu_op_e;

  ////////////////////
  // Format views
  ////////////////////

  // Register fields sit at the same bits in every view
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } instr_i_t;

  // Store immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } instr_s_t;

  // Branch offset, bit 0 implied zero
  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    opcode_e               opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } instr_uf_t;

  // Jump offset, scrambled like the spec
  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } instr_j_t;

  typedef union packed {
    instr_r_t  r;
    instr_i_t  i;
    instr_s_t  s;
    instr_b_t  b;
    instr_uf_t u;
    instr_j_t  j;
  } instr_u;

endpackage

//--- src/rv_core_regfile.sv
// Two-read, one-write register file with x0 tied to zero

`include "rv_core_macros.svh"

module rv_core_regfile (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [`RV_REG_AW-1:0] raddr_a_i,
  input  logic [`RV_REG_AW-1:0] raddr_b_i,
  input  logic [`RV_REG_AW-1:0] waddr_i,
  input  logic                  we_i,
  input  logic [`RV_XLEN-1:0]   wdata_i,
  output logic [`RV_XLEN-1:0]   rdata_a_o,
  output logic [`RV_XLEN-1:0]   rdata_b_o
);

  // x1 to x31 only, no storage for x0
  logic [`RV_XLEN-1:0] regs_q [1:`RV_NREGS-1];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 1; r < `RV_NREGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule
